//--- logic/age_select.sv
`timescale 1ns/1ps

module age_select import store_issue_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               alloc_i,
    input  logic [iq_size-1:0] alloc_onehot_i,
    input  logic [iq_size-1:0] ready_i,
    output logic [iq_size-1:0] grant_o
);
    // older_q[i][j] set means slot i was allocated before slot j.
    logic [iq_size-1:0] older_q [iq_size];
    logic [iq_size-1:0] blocked;

    always_comb begin
        for (int i = 0; i < iq_size; i++) begin
            blocked[i] = 1'b0;
            for (int j = 0; j < iq_size; j++) begin
                if (j != i && ready_i[j] && older_q[j][i]) begin
                    blocked[i] = 1'b1; // an older ready slot wins.
                end
            end
        end
        grant_o = ready_i & ~blocked;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < iq_size; i++) begin
                older_q[i] <= '0;
            end
        end else if (alloc_i) begin
            for (int i = 0; i < iq_size; i++) begin
                if (alloc_onehot_i[i]) begin
                    older_q[i] <= '0; // new slot is youngest.
                end else begin
                    older_q[i] <= older_q[i] | alloc_onehot_i;
                end
            end
        end
    end

endmodule

//--- logic/store_addr_bank.sv
`timescale 1ns/1ps

module store_addr_bank import store_issue_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    disp_valid_i,
    input  disp_store_t             disp_i,
    input  wb_port_t [wb_ports-1:0] wb_i,
    input  redirect_t               redirect_i,
    input  logic [iq_size-1:0]      data_busy_i,
    output logic                    full_o,
    output logic                    alloc_o,
    output logic [iq_size-1:0]      free_onehot_o,
    output logic                    issue_valid_o,
    output addr_issue_t             issue_o
);
    logic [iq_size-1:0] valid_q;
    logic [iq_size-1:0] busy;
    logic [iq_size-1:0] ready;
    logic [iq_size-1:0] grant;
    logic [iq_size-1:0] keep;
    logic [slot_w-1:0]  free_idx;
    logic [slot_w-1:0]  sel_idx;

    logic [preg_w-1:0]  rs1_q [iq_size];
    logic [iq_size-1:0] rs1_rdy_q;
    logic [imm_w-1:0]   imm_q [iq_size];
    store_size_e        size_q [iq_size];
    rob_idx_t           rob_q [iq_size];
    logic [sq_w-1:0]    sq_q [iq_size];

    assign busy    = valid_q | data_busy_i; // slot held until both halves leave.
    assign full_o  = &busy;
    assign alloc_o = disp_valid_i & ~full_o & ~redirect_i.en;

    // lowest free slot.
    always_comb begin
        free_onehot_o = '0;
        free_idx = '0;
        for (int i = iq_size - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_onehot_o = '0;
                free_onehot_o[i] = 1'b1;
                free_idx = slot_w'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < iq_size; i++) begin
            ready[i] = valid_q[i] & rs1_rdy_q[i] & ~redirect_i.en;
            keep[i]  = is_older(rob_q[i], redirect_i.rob_idx);
        end
    end

    age_select u_age (
        .clk            (clk),
        .reset_i        (reset_i),
        .alloc_i        (alloc_o),
        .alloc_onehot_i (free_onehot_o),
        .ready_i        (ready),
        .grant_o        (grant)
    );

    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < iq_size; i++) begin
            if (grant[i]) begin
                sel_idx = slot_w'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
            issue_valid_o <= 1'b0;
        end else begin
            if (redirect_i.en) begin
                valid_q <= valid_q & keep;
            end else begin
                valid_q <= (valid_q | (free_onehot_o & {iq_size{alloc_o}})) & ~grant;
            end
            issue_valid_o <= |grant; // grant is empty during a redirect.
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < iq_size; i++) begin
            if (alloc_o && free_onehot_o[i]) begin
                rs1_rdy_q[i] <= disp_i.rs1_ready | wb_hit(wb_i, disp_i.rs1);
            end else begin
                rs1_rdy_q[i] <= rs1_rdy_q[i] | wb_hit(wb_i, rs1_q[i]);
            end
        end
        if (alloc_o) begin
            rs1_q[free_idx]  <= disp_i.rs1;
            imm_q[free_idx]  <= disp_i.imm;
            size_q[free_idx] <= disp_i.size;
            rob_q[free_idx]  <= disp_i.rob_idx;
            sq_q[free_idx]   <= disp_i.sq_idx;
        end
        issue_o.rs1    <= rs1_q[sel_idx];
        issue_o.imm    <= imm_q[sel_idx];
        issue_o.size   <= size_q[sel_idx];
        issue_o.sq_idx <= sq_q[sel_idx];
    end

endmodule

//--- logic/store_data_bank.sv
`timescale 1ns/1ps

module store_data_bank import store_issue_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    alloc_i,
    input  logic [iq_size-1:0]      free_onehot_i,
    input  disp_store_t             disp_i,
    input  wb_port_t [wb_ports-1:0] wb_i,
    input  redirect_t               redirect_i,
    output logic [iq_size-1:0]      busy_o,
    output logic                    issue_valid_o,
    output data_issue_t             issue_o
);
    logic [iq_size-1:0] valid_q;
    logic [iq_size-1:0] ready;
    logic [iq_size-1:0] grant;
    logic [iq_size-1:0] keep;
    logic [slot_w-1:0]  sel_idx;

    logic [preg_w-1:0]  rs2_q [iq_size];
    logic [iq_size-1:0] rs2_rdy_q;
    rob_idx_t           rob_q [iq_size];
    logic [sq_w-1:0]    sq_q [iq_size];

    assign busy_o = valid_q;

    always_comb begin
        for (int i = 0; i < iq_size; i++) begin
            ready[i] = valid_q[i] & rs2_rdy_q[i] & ~redirect_i.en;
            keep[i]  = is_older(rob_q[i], redirect_i.rob_idx);
        end
    end

    age_select u_age (
        .clk            (clk),
        .reset_i        (reset_i),
        .alloc_i        (alloc_i),
        .alloc_onehot_i (free_onehot_i),
        .ready_i        (ready),
        .grant_o        (grant)
    );

    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < iq_size; i++) begin
            if (grant[i]) begin
                sel_idx = slot_w'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
            issue_valid_o <= 1'b0;
        end else begin
            if (redirect_i.en) begin
                valid_q <= valid_q & keep;
            end else begin
                valid_q <= (valid_q | (free_onehot_i & {iq_size{alloc_i}})) & ~grant;
            end
            issue_valid_o <= |grant;
        end
    end

    // same slot as the address half.
    always_ff @(posedge clk) begin
        for (int i = 0; i < iq_size; i++) begin
            if (alloc_i && free_onehot_i[i]) begin
                rs2_rdy_q[i] <= disp_i.rs2_ready | wb_hit(wb_i, disp_i.rs2);
                rs2_q[i]     <= disp_i.rs2;
                rob_q[i]     <= disp_i.rob_idx;
                sq_q[i]      <= disp_i.sq_idx;
            end else begin
                rs2_rdy_q[i] <= rs2_rdy_q[i] | wb_hit(wb_i, rs2_q[i]);
            end
        end
        issue_o.rs2    <= rs2_q[sel_idx];
        issue_o.sq_idx <= sq_q[sel_idx];
    end

endmodule

//--- logic/store_issue_pkg.sv
package store_issue_pkg;

    localparam int iq_size  = 8;
    localparam int slot_w   = 3;
    localparam int preg_num = 32;
    localparam int preg_w   = 5;
    localparam int xlen     = 32;
    localparam int wb_ports = 2;
    localparam int rob_w    = 5;
    localparam int sq_w     = 4;
    localparam int imm_w    = 12;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } store_size_e;

    typedef struct packed {
        logic             dir; // flips on each ROB wrap.
        logic [rob_w-1:0] idx;
    } rob_idx_t;

    typedef struct packed {
        logic [preg_w-1:0] rs1;
        logic              rs1_ready;
        logic [preg_w-1:0] rs2;
        logic              rs2_ready;
        logic [imm_w-1:0]  imm;
        store_size_e       size;
        rob_idx_t          rob_idx;
        logic [sq_w-1:0]   sq_idx;
    } disp_store_t;

    typedef struct packed {
        logic              en;
        logic [preg_w-1:0] rd;
        logic [xlen-1:0]   value;
    } wb_port_t;

    typedef struct packed {
        logic     en;
        rob_idx_t rob_idx;
    } redirect_t;

    typedef struct packed {
        logic [preg_w-1:0] rs1;
        logic [imm_w-1:0]  imm;
        store_size_e       size;
        logic [sq_w-1:0]   sq_idx;
    } addr_issue_t;

    typedef struct packed {
        logic [preg_w-1:0] rs2;
        logic [sq_w-1:0]   sq_idx;
    } data_issue_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        store_size_e     size;
        logic [sq_w-1:0] sq_idx;
    } store_addr_t;

    typedef struct packed {
        logic [xlen-1:0] data;
        logic [sq_w-1:0] sq_idx;
    } store_data_t;

    // entry survives a redirect only when strictly older than the redirect point.
    function automatic logic is_older(input rob_idx_t entry, input rob_idx_t point);
        if (entry.dir == point.dir) begin
            return entry.idx < point.idx;
        end
        return entry.idx > point.idx;
    endfunction

    function automatic logic wb_hit(input wb_port_t [wb_ports-1:0] wb,
                                    input logic [preg_w-1:0] preg);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < wb_ports; p++) begin
            if (wb[p].en && wb[p].rd == preg) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

endpackage

//--- logic/store_issue_top.sv
`timescale 1ns/1ps

module store_issue_top import store_issue_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    disp_valid_i,
    input  disp_store_t             disp_i,
    input  wb_port_t [wb_ports-1:0] wb_i,
    input  redirect_t               redirect_i,
    output logic                    full_o,
    output logic                    addr_valid_o,
    output store_addr_t             addr_o,
    output logic                    data_valid_o,
    output store_data_t             data_o
);
    logic               alloc;
    logic [iq_size-1:0] free_onehot;
    logic [iq_size-1:0] data_busy;
    logic               addr_issue_valid;
    addr_issue_t        addr_issue;
    logic               data_issue_valid;
    data_issue_t        data_issue;

    store_addr_bank u_addr_bank (
        .clk           (clk),
        .reset_i       (reset_i),
        .disp_valid_i  (disp_valid_i),
        .disp_i        (disp_i),
        .wb_i          (wb_i),
        .redirect_i    (redirect_i),
        .data_busy_i   (data_busy),
        .full_o        (full_o),
        .alloc_o       (alloc),
        .free_onehot_o (free_onehot),
        .issue_valid_o (addr_issue_valid),
        .issue_o       (addr_issue)
    );

    store_data_bank u_data_bank (
        .clk           (clk),
        .reset_i       (reset_i),
        .alloc_i       (alloc),
        .free_onehot_i (free_onehot),
        .disp_i        (disp_i),
        .wb_i          (wb_i),
        .redirect_i    (redirect_i),
        .busy_o        (data_busy),
        .issue_valid_o (data_issue_valid),
        .issue_o       (data_issue)
    );

    store_regread_stage u_regread (
        .clk                (clk),
        .reset_i            (reset_i),
        .wb_i               (wb_i),
        .addr_issue_valid_i (addr_issue_valid),
        .addr_issue_i       (addr_issue),
        .data_issue_valid_i (data_issue_valid),
        .data_issue_i       (data_issue),
        .addr_valid_o       (addr_valid_o),
        .addr_o             (addr_o),
        .data_valid_o       (data_valid_o),
        .data_o             (data_o)
    );

endmodule

//--- logic/store_regread_stage.sv
`timescale 1ns/1ps

module store_regread_stage import store_issue_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    input  wb_port_t [wb_ports-1:0] wb_i,
    input  logic                    addr_issue_valid_i,
    input  addr_issue_t             addr_issue_i,
    input  logic                    data_issue_valid_i,
    input  data_issue_t             data_issue_i,
    output logic                    addr_valid_o,
    output store_addr_t             addr_o,
    output logic                    data_valid_o,
    output store_data_t             data_o
);
    logic [xlen-1:0] rf_q [preg_num];
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] imm_sext;

    // read with write-back bypass, later port wins as in the write.
    always_comb begin
        rs1_val = rf_q[addr_issue_i.rs1];
        rs2_val = rf_q[data_issue_i.rs2];
        for (int p = 0; p < wb_ports; p++) begin
            if (wb_i[p].en && wb_i[p].rd == addr_issue_i.rs1) begin
                rs1_val = wb_i[p].value;
            end
            if (wb_i[p].en && wb_i[p].rd == data_issue_i.rs2) begin
                rs2_val = wb_i[p].value;
            end
        end
    end

    assign imm_sext = {{(xlen - imm_w){addr_issue_i.imm[imm_w-1]}}, addr_issue_i.imm};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 0; r < preg_num; r++) begin
                rf_q[r] <= '0;
            end
            addr_valid_o <= 1'b0;
            data_valid_o <= 1'b0;
        end else begin
            for (int p = 0; p < wb_ports; p++) begin
                if (wb_i[p].en) begin
                    rf_q[wb_i[p].rd] <= wb_i[p].value;
                end
            end
            addr_valid_o <= addr_issue_valid_i;
            data_valid_o <= data_issue_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        addr_o <= '{addr: rs1_val + imm_sext, size: addr_issue_i.size,
                    sq_idx: addr_issue_i.sq_idx};
        data_o <= '{data: rs2_val, sq_idx: data_issue_i.sq_idx};
    end

endmodule

//--- project.f
logic/store_issue_pkg.sv
logic/age_select.sv
logic/store_addr_bank.sv
logic/store_data_bank.sv
logic/store_regread_stage.sv
logic/store_issue_top.sv
testbench/store_issue_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module store_issue_tb -o store_issue_sim -f project.f \
    && ./obj_dir/store_issue_sim | tee /dev/stderr | grep -q "Testbench passed" \
    && echo "simulation run ok" \
    || { echo "simulation run not ok"; exit 1; }

//--- testbench/store_issue_tb.sv
`timescale 1ns/1ps

module store_issue_tb import store_issue_pkg::*; ();
    localparam int num_stores  = 300;
    localparam int cycle_limit = 40 * num_stores + 200;
    localparam int sq_num      = 1 << sq_w;

    typedef enum logic [1:0] {sq_free, sq_live, sq_killed} sq_state_e;

    logic                    clk;
    logic                    reset_i;
    logic                    disp_valid;
    disp_store_t             disp;
    wb_port_t [wb_ports-1:0] wb;
    redirect_t               redirect;
    logic                    full;
    logic                    addr_valid;
    store_addr_t             addr;
    logic                    data_valid;
    store_data_t             data;

    sq_state_e       state [sq_num]; // one model entry per store-queue index.
    disp_store_t     ent [sq_num];
    logic            addr_done [sq_num];
    logic            data_done [sq_num];
    int              rs1_wake [sq_num]; // edge of wakeup, -1 while waiting.
    int              rs2_wake [sq_num];
    int              kill_edge [sq_num];
    int              seq [sq_num]; // dispatch order.
    logic [xlen-1:0] rf_m [preg_num];
    int              cyc;
    int              n_disp;
    int              redir_seq;
    logic            prev_full;
    logic [rob_w:0]  rob_cnt;
    logic [sq_w-1:0] sq_next;

    store_issue_top u_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .disp_valid_i (disp_valid),
        .disp_i       (disp),
        .wb_i         (wb),
        .redirect_i   (redirect),
        .full_o       (full),
        .addr_valid_o (addr_valid),
        .addr_o       (addr),
        .data_valid_o (data_valid),
        .data_o       (data)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > cycle_limit) begin
            stop_on_error($sformatf("timeout, run did not end within %0d cycles", cycle_limit));
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_addr(input string name, input store_addr_t exp, input store_addr_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input store_data_t exp, input store_data_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_full(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
        end
    endtask

    function automatic int live_count();
        int n;
        n = 0;
        for (int k = 0; k < sq_num; k++) begin
            if (state[k] == sq_live) n++;
        end
        return n;
    endfunction

    function automatic logic find_live(input int start, output int idx);
        int k;
        idx = 0;
        for (int n = 0; n < sq_num; n++) begin
            k = (start + n) % sq_num;
            if (state[k] == sq_live) begin
                idx = k;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic find_waiting(input int start, output logic [preg_w-1:0] preg);
        int k;
        preg = '0;
        for (int n = 0; n < sq_num; n++) begin
            k = (start + n) % sq_num;
            if (state[k] == sq_live && rs1_wake[k] < 0) begin
                preg = ent[k].rs1;
                return 1'b1;
            end
            if (state[k] == sq_live && rs2_wake[k] < 0) begin
                preg = ent[k].rs2;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // pulses seen now were issued at the previous edge.
    task automatic check_pulses();
        logic [sq_w-1:0] k;
        store_addr_t     exp_a;
        store_data_t     exp_d;
        if (addr_valid) begin
            k = addr.sq_idx;
            if (state[k] == sq_free || (state[k] == sq_live && addr_done[k])) begin
                stop_on_error($sformatf("address pulse for sq %0d with no pending address", k));
            end else if (state[k] == sq_live) begin
                if (rs1_wake[k] < 0 || cyc - rs1_wake[k] < 2) begin
                    stop_on_error($sformatf("sq %0d address issued before rs1 was ready", k));
                end
                exp_a = '{addr: rf_m[ent[k].rs1] + xlen'($signed(ent[k].imm)),
                          size: ent[k].size, sq_idx: k};
                check_addr("addr_pulse", exp_a, addr);
                addr_done[k] = 1'b1;
            end
        end
        if (data_valid) begin
            k = data.sq_idx;
            if (state[k] == sq_free || (state[k] == sq_live && data_done[k])) begin
                stop_on_error($sformatf("data pulse for sq %0d with no pending data", k));
            end else if (state[k] == sq_live) begin
                if (rs2_wake[k] < 0 || cyc - rs2_wake[k] < 2) begin
                    stop_on_error($sformatf("sq %0d data issued before rs2 was ready", k));
                end
                exp_d = '{data: rf_m[ent[k].rs2], sq_idx: k};
                check_data("data_pulse", exp_d, data);
                data_done[k] = 1'b1;
            end
        end
        for (int n = 0; n < sq_num; n++) begin
            if (state[n] == sq_live && addr_done[n] && data_done[n]) begin
                state[n] = sq_free;
            end else if (state[n] == sq_killed && cyc - kill_edge[n] > 2) begin
                state[n] = sq_free; // late pulses of a flushed store are over.
            end
        end
    endtask

    // dispatch, wakeup and flush seen at the last edge.
    task automatic apply_edge();
        if (disp_valid) begin
            state[disp.sq_idx]     = sq_live;
            ent[disp.sq_idx]       = disp;
            seq[disp.sq_idx]       = n_disp;
            addr_done[disp.sq_idx] = 1'b0;
            data_done[disp.sq_idx] = 1'b0;
            rs1_wake[disp.sq_idx]  = disp.rs1_ready ? cyc : -1;
            rs2_wake[disp.sq_idx]  = disp.rs2_ready ? cyc : -1;
        end
        for (int k = 0; k < sq_num; k++) begin
            if (state[k] == sq_live) begin
                for (int p = 0; p < wb_ports; p++) begin
                    if (wb[p].en && rs1_wake[k] < 0 && ent[k].rs1 == wb[p].rd) rs1_wake[k] = cyc;
                    if (wb[p].en && rs2_wake[k] < 0 && ent[k].rs2 == wb[p].rd) rs2_wake[k] = cyc;
                end
                if (redirect.en && seq[k] >= redir_seq) begin
                    state[k]     = sq_killed; // target and everything dispatched after it.
                    kill_edge[k] = cyc;
                end
            end
        end
    endtask

    task automatic drive_inputs(input logic allow_new);
        logic [preg_w-1:0] preg;
        int                target;
        logic              found;
        disp_valid = 1'b0;
        redirect   = '0;
        wb         = '0;
        if (allow_new) begin
            wb[0] = '{en: 1'($urandom_range(1)), rd: preg_w'($urandom_range(preg_num - 1)),
                      value: $urandom()};
            found = find_live(int'($urandom_range(sq_num - 1)), target);
            if (found && $urandom_range(99) < 4) begin
                redirect  = '{en: 1'b1, rob_idx: ent[target].rob_idx};
                redir_seq = seq[target];
            end else if (!full && state[sq_next] == sq_free && $urandom_range(99) < 70) begin
                disp_valid = 1'b1;
                disp = '{rs1: preg_w'($urandom_range(preg_num - 1)),
                         rs1_ready: 1'($urandom_range(1)),
                         rs2: preg_w'($urandom_range(preg_num - 1)),
                         rs2_ready: 1'($urandom_range(1)),
                         imm: imm_w'($urandom()),
                         size: store_size_e'(2'($urandom_range(2))),
                         rob_idx: rob_idx_t'(rob_cnt),
                         sq_idx: sq_next};
                rob_cnt = rob_cnt + 1'b1;
                sq_next = sq_next + 1'b1;
                n_disp++;
            end
        end
        found = find_waiting(int'($urandom_range(sq_num - 1)), preg);
        if (found && (!allow_new || $urandom_range(99) < 40)) begin
            wb[1] = '{en: 1'b1, rd: preg, value: $urandom()}; // eventually frees a waiter.
        end else if (allow_new && $urandom_range(99) < 30) begin
            wb[1] = '{en: 1'b1, rd: preg_w'($urandom_range(preg_num - 1)), value: $urandom()};
        end
    endtask

    task automatic step(input logic allow_new);
        @(negedge clk);
        for (int p = 0; p < wb_ports; p++) begin
            if (wb[p].en) rf_m[wb[p].rd] = wb[p].value; // later port wins.
        end
        check_pulses();
        check_full("full_flag", live_count() == iq_size, prev_full);
        apply_edge();
        prev_full = full;
        drive_inputs(allow_new);
    endtask

    initial begin
        void'($urandom(32'h72b2_a73b));
        cyc        = 0;
        n_disp     = 0;
        redir_seq  = 0;
        rob_cnt    = '0;
        sq_next    = '0;
        reset_i    = 1'b1;
        disp_valid = 1'b0;
        disp       = '0;
        wb         = '0;
        redirect   = '0;
        for (int k = 0; k < sq_num; k++) state[k] = sq_free;
        for (int r = 0; r < preg_num; r++) rf_m[r] = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_i   = 1'b0;
        prev_full = full;
        while (n_disp < num_stores) step(1'b1);
        while (live_count() > 0) step(1'b0); // drain.
        repeat (4) step(1'b0);
        $display("Testbench passed");
        $finish;
    end

endmodule
